// File: Makefile
RTL = hw/dac_pkg.sv hw/dac_sample_latch.sv hw/dac_bank_encoder.sv \
      hw/dac_instr_queue.sv hw/dac_spi_writer.sv hw/dac_out_top.sv

.PHONY: all run lint clean

all: run

obj_dir/tb_dac_out: build.f $(RTL) sim/tb_dac_out.sv
	verilator --binary --timing -f build.f --top-module tb_dac_out -o tb_dac_out

run: obj_dir/tb_dac_out
	./obj_dir/tb_dac_out 2>&1 | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only -Wall --top-module dac_out_top $(RTL)

clean:
	rm -rf obj_dir sim.log

// File: build.f
hw/dac_pkg.sv
hw/dac_sample_latch.sv
hw/dac_bank_encoder.sv
hw/dac_instr_queue.sv
hw/dac_spi_writer.sv
hw/dac_out_top.sv
sim/tb_dac_out.sv

// File: hw/dac_bank_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module dac_bank_encoder import dac_pkg::*; #(
	parameter int N_CHAN   = 8,  // dac channels in total
	parameter int N_BANK   = 2,  // number of banks
	parameter int BANK_IDX = 0   // position of this bank
) (
	input  wire logic                                clk_in,
	input  wire logic                                rst_n,
	input  wire logic                                start,  // load mask and words
	input  wire logic [N_CHAN/N_BANK-1:0]            mask,   // this bank's valid bits
	input  wire logic [W_DATA*(N_CHAN/N_BANK)-1:0]   data,   // this bank's words
	input  wire logic                                grant,  // queue took the current instr
	output logic                                     req,    // instruction on offer
	output logic [W_INSTR-1:0]                       instr,  // {address, word}
	output logic                                     idle    // nothing pending
);

	localparam int N_LOC = N_CHAN / N_BANK;                       // channels per bank
	localparam int W_LOC = (N_LOC > 1) ? $clog2(N_LOC) : 1;       // local index width
	localparam logic [W_CHS-1:0] BASE = W_CHS'(BANK_IDX * N_LOC); // first global channel

	logic [N_LOC-1:0]        pending;  // channels still to send
	logic [W_DATA*N_LOC-1:0] words;    // held data words
	logic [W_LOC-1:0]        sel_idx;  // lowest pending channel

	// priority encoder, lowest bit wins
	always_comb begin
		sel_idx = '0;
		for (int i = N_LOC - 1; i >= 0; i--)
			if (pending[i])
				sel_idx = W_LOC'(i);
	end

	assign req   = |pending;
	assign idle  = ~req;
	assign instr = {BASE + W_CHS'(sel_idx), words[sel_idx*W_DATA +: W_DATA]};

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n)
			pending <= '0;
		else if (start)
			pending <= mask;
		else if (grant)
			pending[sel_idx] <= 1'b0;  // step to the next channel up
	end

	always_ff @(posedge clk_in) begin
		if (start)
			words <= data;  // no reset, only read behind pending
	end

endmodule

`default_nettype wire

// File: hw/dac_instr_queue.sv
`timescale 1ns/100ps
`default_nettype none

module dac_instr_queue import dac_pkg::*; #(
	parameter int N_BANK     = 2,  // requesting banks
	parameter int FIFO_DEPTH = 8   // queue entries, power of two
) (
	input  wire logic                        clk_in,
	input  wire logic                        rst_n,
	input  wire logic [N_BANK-1:0]           req,        // one per bank encoder
	input  wire logic [N_BANK*W_INSTR-1:0]   instr_bus,  // bank b at b*W_INSTR
	input  wire logic                        pop,        // writer takes the head
	output logic [N_BANK-1:0]                grant,      // one-hot or zero
	output logic [W_INSTR-1:0]               fifo_data,  // head word, show-ahead
	output logic                             fifo_empty
);

	localparam int W_BANK = (N_BANK > 1) ? $clog2(N_BANK) : 1;
	localparam int W_PTR  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	////////////////////
	// arbiter
	////////////////////
	logic [W_BANK-1:0]  win_idx;  // lowest requesting bank
	logic               any_req;
	logic               full;
	logic               wr_en;
	logic               rd_en;
	logic [W_INSTR-1:0] wr_data;

	// fixed priority, lower bank first so frames leave in channel order
	always_comb begin
		win_idx = '0;
		any_req = 1'b0;
		for (int i = N_BANK - 1; i >= 0; i--) begin
			if (req[i]) begin
				win_idx = W_BANK'(i);
				any_req = 1'b1;
			end
		end
	end

	always_comb begin
		grant = '0;
		if (any_req && !full)
			grant[win_idx] = 1'b1;  // held off while full, encoders wait
	end

	assign wr_en   = |grant;
	assign wr_data = instr_bus[win_idx*W_INSTR +: W_INSTR];
	assign rd_en   = pop & ~fifo_empty;  // stray pops on empty ignored

	////////////////////
	// circular fifo
	////////////////////
	logic [W_INSTR-1:0] mem [FIFO_DEPTH];
	logic [W_PTR-1:0]   wr_ptr;
	logic [W_PTR-1:0]   rd_ptr;
	logic [W_PTR:0]     count;    // occupancy, 0..FIFO_DEPTH

	assign full       = (count == (W_PTR+1)'(FIFO_DEPTH));
	assign fifo_empty = (count == '0);
	assign fifo_data  = mem[rd_ptr];  // valid whenever not empty

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == W_PTR'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == W_PTR'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // both or neither
			endcase
		end
	end

	// storage
	always_ff @(posedge clk_in) begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
	end

endmodule

`default_nettype wire

// File: hw/dac_out_top.sv
`timescale 1ns/100ps
`default_nettype none

module dac_out_top import dac_pkg::*; #(
	parameter int N_CHAN     = 8,  // dac channels
	parameter int N_BANK     = 2,  // encoder banks
	parameter int FIFO_DEPTH = 8   // instruction queue depth
) (
	input  wire logic                     clk_in,
	input  wire logic                     rst_n,
	input  wire logic [W_DATA*N_CHAN-1:0] data_packed,  // all channel words
	input  wire logic [N_CHAN-1:0]        data_valid,   // update mask pulse
	output logic                          busy,
	output logic                          sclk,
	output logic                          sync_n,
	output logic                          sdin
);

	localparam int N_LOC = N_CHAN / N_BANK;  // channels per bank

	logic                       bank_start;
	logic [N_CHAN-1:0]          bank_mask;
	logic [W_DATA*N_CHAN-1:0]   bank_data;
	logic [N_BANK-1:0]          bank_idle;
	logic [N_BANK-1:0]          req;
	logic [N_BANK-1:0]          grant;
	logic [N_BANK*W_INSTR-1:0]  instr_bus;   // bank b at b*W_INSTR
	logic [W_INSTR-1:0]         fifo_data;
	logic                       fifo_empty;
	logic                       pop;

	////////////////////
	// input side
	////////////////////
	dac_sample_latch #(.N_CHAN(N_CHAN), .N_BANK(N_BANK)) u_latch (
		.clk_in(clk_in), .rst_n(rst_n),
		.data_packed(data_packed), .data_valid(data_valid),
		.bank_idle(bank_idle),
		.bank_start(bank_start), .bank_mask(bank_mask), .bank_data(bank_data),
		.busy(busy)
	);

	// one encoder per bank of N_LOC channels
	for (genvar b = 0; b < N_BANK; b++) begin : g_bank
		dac_bank_encoder #(.N_CHAN(N_CHAN), .N_BANK(N_BANK), .BANK_IDX(b)) u_enc (
			.clk_in(clk_in), .rst_n(rst_n),
			.start(bank_start),
			.mask(bank_mask[b*N_LOC +: N_LOC]),
			.data(bank_data[b*N_LOC*W_DATA +: N_LOC*W_DATA]),
			.grant(grant[b]),
			.req(req[b]),
			.instr(instr_bus[b*W_INSTR +: W_INSTR]),
			.idle(bank_idle[b])
		);
	end

	////////////////////
	// queue and serial side
	////////////////////
	dac_instr_queue #(.N_BANK(N_BANK), .FIFO_DEPTH(FIFO_DEPTH)) u_queue (
		.clk_in(clk_in), .rst_n(rst_n),
		.req(req), .instr_bus(instr_bus), .pop(pop),
		.grant(grant), .fifo_data(fifo_data), .fifo_empty(fifo_empty)
	);

	dac_spi_writer u_writer (
		.clk_in(clk_in), .rst_n(rst_n),
		.fifo_data(fifo_data), .fifo_empty(fifo_empty),
		.pop(pop), .sclk(sclk), .sync_n(sync_n), .sdin(sdin)
	);

endmodule

`default_nettype wire

// File: hw/dac_pkg.sv
`default_nettype none

package dac_pkg;

	////////////////////
	// field widths
	////////////////////
	localparam int W_DATA  = 16;                       // one dac data word
	localparam int W_CHS   = 4;                        // dac address nibble
	localparam int W_CMD   = 4;                        // command nibble
	localparam int W_FRAME = W_CMD + W_CHS + W_DATA;   // serial frame, 24 bits
	localparam int W_INSTR = W_CHS + W_DATA;           // queued word, cmd added later

	////////////////////
	// dac commands
	////////////////////
	typedef enum logic [W_CMD-1:0] {
		CMD_WRITE        = 4'h0,  // write input register only
		CMD_WRITE_UPDATE = 4'h3   // write and update the addressed channel
	} dac_cmd_e;

	// serial writer states
	typedef enum logic [1:0] {
		ST_IDLE,   // waiting for a queued instruction
		ST_SHIFT,  // frame on the wire, sync_n low
		ST_GAP     // sync_n high between frames
	} spi_state_e;

endpackage

`default_nettype wire

// File: hw/dac_sample_latch.sv
`timescale 1ns/100ps
`default_nettype none

module dac_sample_latch import dac_pkg::*; #(
	parameter int N_CHAN = 8,  // dac channels
	parameter int N_BANK = 2   // encoder banks
) (
	input  wire logic                     clk_in,
	input  wire logic                     rst_n,
	input  wire logic [W_DATA*N_CHAN-1:0] data_packed,  // channel k at bits 16k+:16
	input  wire logic [N_CHAN-1:0]        data_valid,   // one-cycle update pulse
	input  wire logic [N_BANK-1:0]        bank_idle,    // per-bank drained flags
	output logic                          bank_start,   // load pulse to every encoder
	output logic [N_CHAN-1:0]             bank_mask,    // held mask, sliced per bank on top
	output logic [W_DATA*N_CHAN-1:0]      bank_data,    // held words, sliced the same way
	output logic                          busy          // back-pressure toward the source
);

	logic accept;   // update taken this cycle
	logic running;  // banks loaded, watching idle flags

	// pulses during busy are dropped here
	assign accept = ~busy & (|data_valid);

	////////////////////
	// control
	////////////////////
	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			running    <= 1'b0;
			bank_start <= 1'b0;
		end else begin
			bank_start <= accept;                  // start one cycle after accept
			if (accept)
				busy <= 1'b1;
			if (bank_start)
				running <= 1'b1;                   // encoders hold the mask from here on
			else if (running && (&bank_idle)) begin
				running <= 1'b0;
				busy    <= 1'b0;                   // every bank drained
			end
		end
	end

	// payload, captured on accept only
	always_ff @(posedge clk_in) begin
		if (accept) begin
			bank_mask <= data_valid;
			bank_data <= data_packed;
		end
	end

endmodule

`default_nettype wire

// File: hw/dac_spi_writer.sv
`timescale 1ns/100ps
`default_nettype none

module dac_spi_writer import dac_pkg::*; (
	input  wire logic               clk_in,
	input  wire logic               rst_n,
	input  wire logic [W_INSTR-1:0] fifo_data,   // {address, word} at the queue head
	input  wire logic               fifo_empty,
	output logic                    pop,         // take the head word this cycle
	output logic                    sclk,        // low half then high half per bit
	output logic                    sync_n,      // frame strobe, active low
	output logic                    sdin         // serial data, msb first
);

	localparam int N_HALF  = 2 * W_FRAME;        // half-bit cycles per frame, 48
	localparam int W_CNT   = $clog2(N_HALF);
	localparam int GAP_CYC = 2;                  // idle cycles after sync_n rises

	spi_state_e         state;
	logic [W_FRAME-1:0] shreg;    // outgoing frame
	logic [W_CNT-1:0]   cnt;      // half-bit counter
	logic [1:0]         gap_cnt;  // cycles spent in the gap

	// pop only from idle, word is already on fifo_data
	assign pop  = (state == ST_IDLE) & ~fifo_empty;
	assign sdin = shreg[W_FRAME-1];  // shreg empties to zero, so sdin rests low

	////////////////////
	// frame fsm
	////////////////////
	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			shreg   <= '0;
			cnt     <= '0;
			gap_cnt <= '0;
			sclk    <= 1'b0;
			sync_n  <= 1'b1;
		end else begin
			case (state)
				ST_IDLE: begin
					if (pop) begin
						shreg  <= {CMD_WRITE_UPDATE, fifo_data};  // command in front
						cnt    <= '0;
						sclk   <= 1'b0;
						sync_n <= 1'b0;                           // low the cycle after pop
						state  <= ST_SHIFT;
					end
				end
				ST_SHIFT: begin
					if (cnt == W_CNT'(N_HALF - 1)) begin
						sclk    <= 1'b0;
						sync_n  <= 1'b1;                          // frame done
						shreg   <= shreg << 1;                    // last bit off, line to zero
						gap_cnt <= '0;
						state   <= ST_GAP;
					end else begin
						cnt  <= cnt + 1'b1;
						sclk <= ~sclk;
						if (sclk)
							shreg <= shreg << 1;  // next bit on the falling edge
					end
				end
				ST_GAP: begin
					if (gap_cnt == 2'(GAP_CYC - 1))
						state <= ST_IDLE;
					else
						gap_cnt <= gap_cnt + 1'b1;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_dac_out.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dac_out;

	localparam int N_STIM   = 7;     // table entries
	localparam int T_BUSY   = 2000;  // cycle limit on one busy wait
	localparam int T_DRAIN  = 4000;  // cycle limit on the final drain
	localparam int T_QUIET  = 120;   // roughly two frames of silence
	localparam int MAX_HELD = 9;     // fifo depth plus the frame on the wire

	logic         clk_in;
	logic         rst_n;
	logic [127:0] data_packed;  // channel k at bits 16k+:16
	logic [7:0]   data_valid;
	logic         busy;
	logic         sclk;
	logic         sync_n;
	logic         sdin;

	logic [23:0] exp_q [$];    // expected frames, oldest first
	logic [15:0] lfsr;         // data generator state
	logic [23:0] rx_shift;     // frame being assembled
	int          rx_bits;
	logic        sclk_q;       // previous sample, for edge detection
	logic        sync_q;
	int          err_cnt;
	int          frames_seen;
	int          frames_exp;
	bit          timed_out;

	dac_out_top DUT (
		.clk_in(clk_in), .rst_n(rst_n),
		.data_packed(data_packed), .data_valid(data_valid),
		.busy(busy), .sclk(sclk), .sync_n(sync_n), .sdin(sdin)
	);

	always #5 clk_in = ~clk_in;  // 10 ns period

	////////////////////
	// helpers
	////////////////////
	// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic next_word(output logic [15:0] w);
		w = '0;
		for (int b = 0; b < 16; b++) begin
			lfsr = lfsr_step(lfsr);
			w    = {w[14:0], lfsr[0]};  // one step per bit
		end
	endtask

	// {apply while busy, valid mask}
	function automatic logic [8:0] stim_entry(input int i);
		case (i)
			0:       return {1'b0, 8'h04};  // lower bank, ch 2 alone
			1:       return {1'b0, 8'h20};  // upper bank, ch 5 alone
			2:       return {1'b0, 8'hFF};  // every channel
			3:       return {1'b0, 8'h5A};  // ch 1 3 4 6
			4:       return {1'b0, 8'hFF};  // back to back pair, fifo overflows
			5:       return {1'b0, 8'hFF};
			6:       return {1'b1, 8'h81};  // lands during busy, must vanish
			default: return '0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			err_cnt++;
			$display("ERR %s got %h expected %h at %0t", name, got, want, $time);
		end
	endtask

	// with busy low the banks are empty, only the fifo and the wire hold frames
	task automatic check_held;
		if (exp_q.size() > MAX_HELD) begin
			err_cnt++;
			$display("busy fell while %0d frames were still held back", exp_q.size());
		end
	endtask

	task automatic wait_busy_low(input int limit);
		int n;
		n = 0;
		@(negedge clk_in);
		while (busy && n < limit) begin
			@(negedge clk_in);
			n++;
		end
		if (busy) begin
			timed_out = 1'b1;
			err_cnt++;
			$display("timeout: busy stayed high for %0d cycles", limit);
		end else
			check_held();
	endtask

	////////////////////
	// frame monitor
	////////////////////
	task automatic frame_done;
		logic [23:0] want;
		frames_seen++;
		if (rx_bits != 24) begin
			err_cnt++;
			$display("frame ended after %0d bits instead of 24", rx_bits);
		end else if (exp_q.size() == 0) begin
			err_cnt++;
			$display("frame %h arrived while no frame was expected", rx_shift);
		end else begin
			want = exp_q.pop_front();
			check_value("frame", 32'(rx_shift), 32'(want));
		end
	endtask

	// sampled mid-cycle, far from the clk_in edge that moves the outputs
	always @(negedge clk_in) begin
		if (!rst_n) begin
			rx_bits = 0;
			sclk_q  = 1'b0;
			sync_q  = 1'b1;
		end else begin
			if (sclk && !sclk_q && !sync_n) begin
				rx_shift = {rx_shift[22:0], sdin};  // msb first
				rx_bits++;
			end
			if (sync_n && !sync_q) begin
				frame_done();
				rx_bits = 0;
			end
			sclk_q = sclk;
			sync_q = sync_n;
		end
	end

	////////////////////
	// stimulus
	////////////////////
	initial begin
		logic [8:0]  ent;
		logic [15:0] w;
		int          n;
		clk_in      = 1'b0;
		rst_n       = 1'b0;
		data_packed = '0;
		data_valid  = '0;
		lfsr        = 16'd50;
		err_cnt     = 0;
		frames_seen = 0;
		frames_exp  = 0;
		timed_out   = 1'b0;
		repeat (10) @(negedge clk_in);
		rst_n = 1'b1;
		@(negedge clk_in);
		check_value("sync_n", 32'(sync_n), 32'd1);  // idle line after reset
		check_value("sclk", 32'(sclk), 32'd0);
		check_value("sdin", 32'(sdin), 32'd0);
		check_value("busy", 32'(busy), 32'd0);

		for (int i = 0; i < N_STIM; i++) begin
			ent = stim_entry(i);
			if (ent[8]) begin
				@(negedge clk_in);
				check_value("busy", 32'(busy), 32'd1);  // must hit a busy window
			end else
				wait_busy_low(T_BUSY);  // applied the cycle busy is seen low
			if (timed_out)
				break;
			for (int ch = 0; ch < 8; ch++) begin
				if (ent[ch])
					next_word(w);
				else
					w = {8'hA5, 8'(ch)};  // filler, never sent
				data_packed[ch*16 +: 16] = w;
				if (ent[ch] && !ent[8]) begin
					exp_q.push_back({4'h3, 4'(ch), w});  // write and update, addr, data
					frames_exp++;
				end
			end
			data_valid = ent[7:0];
			@(negedge clk_in);
			data_valid = '0;
			if (!ent[8])
				check_value("busy", 32'(busy), 32'd1);  // accepted update
		end

		// let every frame leave, then watch the line for strays
		if (!timed_out) begin
			n = 0;
			while (busy && n < T_DRAIN) begin
				@(negedge clk_in);
				n++;
			end
			if (!busy)
				check_held();  // stalled banks keep busy high
			while ((exp_q.size() != 0 || busy || !sync_n) && n < T_DRAIN) begin
				@(negedge clk_in);
				n++;
			end
			if (exp_q.size() != 0 || busy || !sync_n) begin
				err_cnt++;
				$display("timeout: %0d frames never arrived", exp_q.size());
			end else
				repeat (T_QUIET) @(negedge clk_in);
		end

		check_value("frame_count", 32'(frames_seen), 32'(frames_exp));
		$display("errors %0d, frames %0d of %0d", err_cnt, frames_seen, frames_exp);
		if (err_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
